// File: hw/timer_defines.svh
`ifndef TIMER_DEFINES_SVH
`define TIMER_DEFINES_SVH

// APB address bus width
`define TIMER_ADDR_WIDTH 32

// APB data bus and register width
`define TIMER_DATA_WIDTH 32

// One strobe bit per byte lane
`define TIMER_STRB_WIDTH (`TIMER_DATA_WIDTH / 8)

// Decoded words, index 0 up to this minus one
`define TIMER_REG_COUNT 6

`endif

// File: hw/timer_pkg.sv
`include "timer_defines.svh"

package timer_pkg;

    typedef logic [`TIMER_ADDR_WIDTH-1:0] addr_t;
    typedef logic [`TIMER_DATA_WIDTH-1:0] data_t;
    typedef logic [`TIMER_STRB_WIDTH-1:0] strb_t;

    // Word index of each software register
    typedef enum logic [11:0] {
        REG_CONTROL     = 12'h000, // Bit 0 enables the timer
        REG_PRESCALER   = 12'h001,
        REG_VALUE       = 12'h002,
        REG_AUTO_RELOAD = 12'h003,
        REG_EVENTS      = 12'h004, // Write 1 to clear
        REG_IRQ_ENABLE  = 12'h005
    } reg_idx_e;

endpackage

// File: hw/timer_pause_ctrl.sv
`timescale 1ns/1ps

module timer_pause_ctrl (
    input  logic seq,
    input  logic rst,

    input  logic pause_req,
    output logic pause_ack,

    output logic freeze,
    output logic pause_enter,
    output logic pause_leave
);

    // Block is frozen once the request has been acknowledged
    assign freeze = pause_req && pause_ack;

    // High during the cycle whose closing edge moves the acknowledge
    assign pause_enter = pause_req && !pause_ack;
    assign pause_leave = !pause_req && pause_ack;

    always_ff @(posedge seq) begin
        if (rst) begin
            pause_ack <= 1'b1; // Start paused
        end
        else if (pause_enter) begin
            pause_ack <= 1'b1;
        end
        else if (pause_leave) begin
            pause_ack <= 1'b0;
        end
    end

    // Acknowledge only follows a pending mismatch with the request
    ack_follows_req: assert property (
        @(posedge seq) disable iff (rst)
        !$stable(pause_ack) |-> $past(pause_req != pause_ack)
    ) else $error("pause_ack moved without a pending request change");

    // Never entering and leaving at once
    pulses_exclusive: assert property (
        @(posedge seq) disable iff (rst)
        !(pause_enter && pause_leave)
    ) else $error("pause_enter and pause_leave both high");

endmodule

// File: hw/timer_counter.sv
`timescale 1ns/1ps

module timer_counter (
    input  logic              seq,
    input  logic              rst,

    input  logic              freeze,
    input  logic              enable,

    input  timer_pkg::data_t  prescaler,
    input  timer_pkg::data_t  auto_reload,

    input  logic              value_we,
    input  timer_pkg::data_t  value_wdata,

    output timer_pkg::data_t  value,
    output logic              reload_tick
);

    timer_pkg::data_t clk_count;
    logic             div_tick;
    logic             at_reload;

    // Divided tick every prescaler+1 clocks
    assign div_tick  = enable && (clk_count >= prescaler);
    assign at_reload = (value == auto_reload);

    always_ff @(posedge seq) begin
        if (rst) begin
            clk_count   <= '0;
            value       <= '0;
            reload_tick <= 1'b0;
        end
        else if (!freeze) begin
            reload_tick <= 1'b0;

            if (!enable) begin
                clk_count <= '0; // Divider restarts on next enable
            end
            else if (div_tick) begin
                clk_count <= '0;
                if (at_reload) begin
                    value       <= '0;
                    reload_tick <= 1'b1;
                end
                else begin
                    value <= value + 1'b1;
                end
            end
            else begin
                clk_count <= clk_count + 1'b1;
            end

            // Software write overrides the count step
            if (value_we) begin
                value <= value_wdata;
            end
        end
    end

    // A wrap is only ever taken while the timer was running
    tick_needs_enable: assert property (
        @(posedge seq) disable iff (rst)
        reload_tick |-> $past(enable)
    ) else $error("reload_tick without enable");

endmodule

// File: hw/timer_apb_regs.sv
`timescale 1ns/1ps

`include "timer_defines.svh"

module timer_apb_regs (
    input  logic              seq,
    input  logic              rst,

    input  timer_pkg::addr_t  paddr,
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  timer_pkg::data_t  pwdata,
    input  timer_pkg::strb_t  pstrb,
    output logic              pready,
    output timer_pkg::data_t  prdata,
    output logic              pslverr,

    input  logic              pause_req,
    input  logic              pause_ack,
    input  logic              freeze,
    input  logic              pause_enter,
    input  logic              pause_leave,

    input  timer_pkg::data_t  value,
    input  logic              reload_tick,

    output logic              enable,
    output timer_pkg::data_t  prescaler,
    output timer_pkg::data_t  auto_reload,
    output logic              value_we,
    output timer_pkg::data_t  value_wdata,

    output logic              irq
);

    localparam int IDX_LSB   = $clog2(`TIMER_STRB_WIDTH);
    localparam int IDX_WIDTH = `TIMER_ADDR_WIDTH - IDX_LSB;

    timer_pkg::data_t     control;
    timer_pkg::data_t     irq_enable;
    logic                 arr_event;    // Auto-reload event flag

    logic [IDX_WIDTH-1:0] word_idx;
    logic                 idx_hit;
    timer_pkg::reg_idx_e  reg_idx;
    timer_pkg::data_t     byte_mask;
    timer_pkg::data_t     rd_data;
    logic                 access;
    logic                 wr;
    logic                 events_w1c;

    // Old word with the strobed bytes replaced
    function automatic timer_pkg::data_t merge(
        input timer_pkg::data_t old_word,
        input timer_pkg::data_t new_word,
        input timer_pkg::data_t mask
    );
        return (new_word & mask) | (old_word & ~mask);
    endfunction

    always_comb begin
        word_idx = paddr[`TIMER_ADDR_WIDTH-1:IDX_LSB];
        idx_hit  = (word_idx < `TIMER_REG_COUNT);
        reg_idx  = timer_pkg::reg_idx_e'(word_idx[11:0]);

        for (int i = 0; i < `TIMER_STRB_WIDTH; i++) begin
            byte_mask[i*8 +: 8] = {8{pstrb[i]}};
        end

        case (reg_idx)
            timer_pkg::REG_CONTROL:     rd_data = control;
            timer_pkg::REG_PRESCALER:   rd_data = prescaler;
            timer_pkg::REG_VALUE:       rd_data = value;
            timer_pkg::REG_AUTO_RELOAD: rd_data = auto_reload;
            timer_pkg::REG_EVENTS:      rd_data = {{(`TIMER_DATA_WIDTH-1){1'b0}}, arr_event};
            timer_pkg::REG_IRQ_ENABLE:  rd_data = irq_enable;
            default:                    rd_data = '0;
        endcase
    end

    // Pending transfer, never decoded while a pause is requested
    assign access = psel && !pready && !pause_req;
    assign wr     = access && pwrite && idx_hit;

    assign value_we    = wr && (reg_idx == timer_pkg::REG_VALUE);
    assign value_wdata = merge(value, pwdata, byte_mask);

    assign events_w1c = wr && (reg_idx == timer_pkg::REG_EVENTS) && pwdata[0] && byte_mask[0];

    assign enable = control[0];

    assign irq = enable && !pause_ack && arr_event && irq_enable[0];

    always_ff @(posedge seq) begin
        if (rst) begin
            control     <= '0;
            prescaler   <= '0;
            auto_reload <= '0;
            irq_enable  <= '0;
            pready      <= 1'b0;
            prdata      <= '0;
            pslverr     <= 1'b0;
        end
        else if (!freeze) begin
            if (access) begin
                pready  <= 1'b1;
                pslverr <= !idx_hit; // Unmapped index
                prdata  <= (pwrite || !idx_hit) ? '0 : rd_data;

                if (wr) begin
                    case (reg_idx)
                        timer_pkg::REG_CONTROL:     control     <= merge(control, pwdata, byte_mask);
                        timer_pkg::REG_PRESCALER:   prescaler   <= merge(prescaler, pwdata, byte_mask);
                        timer_pkg::REG_AUTO_RELOAD: auto_reload <= merge(auto_reload, pwdata, byte_mask);
                        timer_pkg::REG_IRQ_ENABLE:  irq_enable  <= merge(irq_enable, pwdata, byte_mask);
                        default: ; // Value and events handled elsewhere
                    endcase
                end
            end
            else if (!pause_ack && psel && penable && pready) begin
                pready  <= 1'b0; // Access phase done
                prdata  <= '0;
                pslverr <= 1'b0;
            end
            else if (pause_enter) begin
                // Any access during the pause errors out at once
                pready  <= 1'b1;
                prdata  <= '0;
                pslverr <= 1'b1;
            end
            else if (pause_leave) begin
                pready  <= 1'b0;
                prdata  <= '0;
                pslverr <= 1'b0;
            end
        end
    end

    always_ff @(posedge seq) begin
        if (rst) begin
            arr_event <= 1'b0;
        end
        else if (!freeze) begin
            if (!enable) begin
                arr_event <= 1'b0;
            end
            else if (reload_tick) begin
                arr_event <= 1'b1; // New event beats a clear
            end
            else if (events_w1c) begin
                arr_event <= 1'b0;
            end
        end
    end

    err_with_ready: assert property (
        @(posedge seq) disable iff (rst)
        pslverr |-> pready
    ) else $error("pslverr without pready");

    // Pause silences the interrupt across the whole handshake
    no_irq_paused: assert property (
        @(posedge seq) disable iff (rst)
        pause_ack |-> !irq
    ) else $error("irq high while paused");

endmodule

// File: hw/apb_timer.sv
`timescale 1ns/1ps

module apb_timer (
    input  logic              seq,
    input  logic              rst,

    input  timer_pkg::addr_t  paddr,
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  timer_pkg::data_t  pwdata,
    input  timer_pkg::strb_t  pstrb,
    output logic              pready,
    output timer_pkg::data_t  prdata,
    output logic              pslverr,

    input  logic              pause_req,
    output logic              pause_ack,

    output logic              irq
);

    logic             freeze;
    logic             pause_enter;
    logic             pause_leave;

    logic             enable;
    timer_pkg::data_t prescaler;
    timer_pkg::data_t auto_reload;
    logic             value_we;
    timer_pkg::data_t value_wdata;
    timer_pkg::data_t value;
    logic             reload_tick;

    timer_pause_ctrl u_pause (
        .seq         (seq),
        .rst         (rst),
        .pause_req   (pause_req),
        .pause_ack   (pause_ack),
        .freeze      (freeze),
        .pause_enter (pause_enter),
        .pause_leave (pause_leave)
    );

    timer_counter u_counter (
        .seq         (seq),
        .rst         (rst),
        .freeze      (freeze),
        .enable      (enable),
        .prescaler   (prescaler),
        .auto_reload (auto_reload),
        .value_we    (value_we),
        .value_wdata (value_wdata),
        .value       (value),
        .reload_tick (reload_tick)
    );

    timer_apb_regs u_regs (
        .seq         (seq),
        .rst         (rst),
        .paddr       (paddr),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .pwdata      (pwdata),
        .pstrb       (pstrb),
        .pready      (pready),
        .prdata      (prdata),
        .pslverr     (pslverr),
        .pause_req   (pause_req),
        .pause_ack   (pause_ack),
        .freeze      (freeze),
        .pause_enter (pause_enter),
        .pause_leave (pause_leave),
        .value       (value),
        .reload_tick (reload_tick),
        .enable      (enable),
        .prescaler   (prescaler),
        .auto_reload (auto_reload),
        .value_we    (value_we),
        .value_wdata (value_wdata),
        .irq         (irq)
    );

endmodule

// File: testbench/tb_apb_timer.sv
`timescale 1ns/1ps

`include "timer_defines.svh"

module tb_apb_timer;

    localparam logic [2:0] OP_WRITE    = 3'd0;
    localparam logic [2:0] OP_READ     = 3'd1;
    localparam logic [2:0] OP_READ_MAX = 3'd2; // Read data may not exceed exp
    localparam logic [2:0] OP_IRQ      = 3'd3; // Samples irq without a bus access

    localparam int PRESCALE     = 3;
    localparam int RELOAD       = 4;
    localparam int EVENT_WAIT   = (PRESCALE + 1) * (RELOAD + 1) + 5;
    localparam int PREADY_LIMIT = 8;

    typedef struct packed {
        logic [2:0]  test_no;
        logic [2:0]  op;
        logic [11:0] idx;
        logic [31:0] wdata;
        logic [3:0]  strb;
        logic [31:0] exp;
        logic        exp_err;
        logic [7:0]  wait_cyc; // Idle cycles before the operation
    } step_t;

    logic             seq;
    logic             rst;
    timer_pkg::addr_t paddr;
    logic             psel;
    logic             penable;
    logic             pwrite;
    timer_pkg::data_t pwdata;
    timer_pkg::strb_t pstrb;
    logic             pready;
    timer_pkg::data_t prdata;
    logic             pslverr;
    logic             pause_req;
    logic             pause_ack;
    logic             irq;

    step_t            steps[$];
    timer_pkg::data_t shadow [`TIMER_REG_COUNT];
    integer           seed;
    int               checks;
    int               errors;
    bit               table_ready = 1'b0;

    apb_timer dut (
        .seq       (seq),
        .rst       (rst),
        .paddr     (paddr),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .pwdata    (pwdata),
        .pstrb     (pstrb),
        .pready    (pready),
        .prdata    (prdata),
        .pslverr   (pslverr),
        .pause_req (pause_req),
        .pause_ack (pause_ack),
        .irq       (irq)
    );

    initial begin
        seq = 1'b0;
        forever #2 seq = ~seq;
    end

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL t=%0t %s got=%h expected=%h", $time, name, got, exp);
        end
    endtask

    // Byte lanes with a strobe take the new data
    function automatic logic [31:0] masked_write(input logic [31:0] old_word,
                                                 input logic [31:0] wd, input logic [3:0] strb);
        logic [31:0] res;
        res = old_word;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) res[b*8 +: 8] = wd[b*8 +: 8];
        end
        return res;
    endfunction

    task automatic add_step(input logic [2:0] test_no, input logic [2:0] op,
                            input logic [11:0] idx, input logic [31:0] wd, input logic [3:0] strb,
                            input logic [31:0] exp, input logic exp_err, input int wait_cyc);
        steps.push_back('{test_no, op, idx, wd, strb, exp, exp_err, 8'(wait_cyc)});
    endtask

    task automatic add_write(input logic [2:0] test_no, input logic [11:0] idx,
                             input logic [31:0] wd, input logic [3:0] strb);
        if (idx < `TIMER_REG_COUNT) begin
            shadow[idx] = masked_write(shadow[idx], wd, strb);
        end
        add_step(test_no, OP_WRITE, idx, wd, strb, '0, idx >= `TIMER_REG_COUNT, 0);
    endtask

    task automatic build_table();
        logic [31:0] r;
        logic [31:0] wd;
        logic [11:0] idx;
        foreach (shadow[i]) shadow[i] = '0;
        for (int i = 0; i < `TIMER_REG_COUNT; i++) begin
            add_step(1, OP_READ, 12'(i), '0, '0, '0, 1'b0, 0);
        end
        // Random strobed writes read back against the shadow
        for (int k = 0; k < 10; k++) begin
            r = $random(seed);
            case (r[1:0])
                2'd0:    idx = timer_pkg::REG_CONTROL;
                2'd1:    idx = timer_pkg::REG_PRESCALER;
                2'd2:    idx = timer_pkg::REG_AUTO_RELOAD;
                default: idx = timer_pkg::REG_IRQ_ENABLE;
            endcase
            wd = $random(seed);
            r  = $random(seed);
            add_write(2, idx, wd, r[3:0]);
            add_step(2, OP_READ, idx, '0, '0, shadow[idx], 1'b0, 0);
        end
        add_step(2, OP_READ, 12'd6, '0, '0, '0, 1'b1, 0);
        add_step(2, OP_READ, 12'h0ff, '0, '0, '0, 1'b1, 0);
        add_write(2, 12'd7, 32'hffff_ffff, 4'hf);
        // Periodic event with the interrupt enabled
        add_write(3, timer_pkg::REG_CONTROL, 32'd0, 4'hf);
        add_write(3, timer_pkg::REG_PRESCALER, PRESCALE, 4'hf);
        add_write(3, timer_pkg::REG_AUTO_RELOAD, RELOAD, 4'hf);
        add_write(3, timer_pkg::REG_IRQ_ENABLE, 32'd1, 4'hf);
        add_write(3, timer_pkg::REG_VALUE, 32'd0, 4'hf);
        add_write(3, timer_pkg::REG_CONTROL, 32'd1, 4'hf);
        add_step(3, OP_READ, timer_pkg::REG_EVENTS, '0, '0, 32'd1, 1'b0, EVENT_WAIT);
        add_step(3, OP_IRQ, '0, '0, '0, 32'd1, 1'b0, 0);
        add_step(3, OP_READ, timer_pkg::REG_CONTROL, '0, '0, shadow[0], 1'b0, 0);
        add_step(3, OP_READ_MAX, timer_pkg::REG_VALUE, '0, '0, RELOAD, 1'b0, 0);
        // Long reload keeps a new event away from the clear
        add_write(4, timer_pkg::REG_AUTO_RELOAD, 32'd1000, 4'hf);
        add_write(4, timer_pkg::REG_EVENTS, 32'd1, 4'hf);
        add_step(4, OP_READ, timer_pkg::REG_EVENTS, '0, '0, 32'd0, 1'b0, 0);
        add_step(4, OP_IRQ, '0, '0, '0, 32'd0, 1'b0, 0);
        add_write(4, timer_pkg::REG_IRQ_ENABLE, 32'd0, 4'hf);
        add_write(4, timer_pkg::REG_VALUE, 32'd0, 4'hf);
        add_write(4, timer_pkg::REG_AUTO_RELOAD, RELOAD, 4'hf);
        add_step(4, OP_READ, timer_pkg::REG_EVENTS, '0, '0, 32'd1, 1'b0, EVENT_WAIT);
        add_step(4, OP_IRQ, '0, '0, '0, 32'd0, 1'b0, 0);
        add_write(5, timer_pkg::REG_IRQ_ENABLE, 32'd1, 4'hf);
        add_step(5, OP_IRQ, '0, '0, '0, 32'd1, 1'b0, 0);
        add_write(6, timer_pkg::REG_CONTROL, 32'd0, 4'hf);
        add_step(6, OP_READ, timer_pkg::REG_EVENTS, '0, '0, 32'd0, 1'b0, 0);
        add_step(6, OP_IRQ, '0, '0, '0, 32'd0, 1'b0, 0);
        add_write(6, timer_pkg::REG_VALUE, 32'h1234_5678, 4'hf);
        add_step(6, OP_READ, timer_pkg::REG_VALUE, '0, '0, shadow[2], 1'b0, 0);
        wd = $random(seed);
        r  = $random(seed);
        add_write(6, timer_pkg::REG_VALUE, wd, r[3:0] | 4'b0001);
        add_step(6, OP_READ, timer_pkg::REG_VALUE, '0, '0, shadow[2], 1'b0, 0);
    endtask

    // Setup and access phases on consecutive falling edges
    task automatic apb_transfer(input logic write, input logic [11:0] idx, input logic [31:0] wd,
                                input logic [3:0] strb, output logic [31:0] rdata,
                                output logic err);
        int cycles;
        paddr   = {18'd0, idx, 2'b00};
        pwrite  = write;
        pwdata  = wd;
        pstrb   = write ? strb : 4'h0;
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge seq);
        penable = 1'b1;
        cycles  = 0;
        while (!pready && cycles < PREADY_LIMIT) begin
            @(negedge seq);
            cycles++;
        end
        if (!pready) begin
            errors++;
            $display("APB transfer to index %0d never saw pready", idx);
        end
        rdata = prdata;
        err   = pslverr;
        @(negedge seq);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input logic [11:0] idx, input logic [31:0] wd,
                             input logic [3:0] strb, output logic err);
        logic [31:0] unused;
        apb_transfer(1'b1, idx, wd, strb, unused, err);
    endtask

    task automatic apb_read(input logic [11:0] idx, output logic [31:0] rdata, output logic err);
        apb_transfer(1'b0, idx, '0, '0, rdata, err);
    endtask

    task automatic apply_step(input step_t s);
        logic [31:0] rdata;
        logic        err;
        repeat (s.wait_cyc) @(negedge seq);
        case (s.op)
            OP_WRITE: begin
                apb_write(s.idx, s.wdata, s.strb, err);
                check($sformatf("pslverr idx %0d", s.idx), err, s.exp_err);
            end
            OP_READ: begin
                apb_read(s.idx, rdata, err);
                check($sformatf("prdata idx %0d", s.idx), rdata, s.exp);
                check($sformatf("pslverr idx %0d", s.idx), err, s.exp_err);
            end
            OP_READ_MAX: begin
                apb_read(s.idx, rdata, err);
                check($sformatf("prdata idx %0d within limit", s.idx), rdata <= s.exp, 1);
            end
            default: check("irq", irq, s.exp[0]);
        endcase
    endtask

    task automatic run_table(input int test_no);
        foreach (steps[i]) begin
            if (steps[i].test_no == test_no) apply_step(steps[i]);
        end
    endtask

    task automatic wait_ack(input logic level, input int bound);
        int cycles;
        cycles = 0;
        while (pause_ack !== level && cycles < bound) begin
            @(negedge seq);
            cycles++;
        end
        check("pause_ack", pause_ack, level);
    endtask

    task automatic report_test(input int test_no, input string name, input int errors_before);
        $display("test %0d %s: %s (%0d errors)", test_no, name,
                 (errors == errors_before) ? "ok" : "mismatch", errors - errors_before);
    endtask

    initial begin
        logic [31:0] v_before;
        logic [31:0] v_after;
        logic [31:0] rdata;
        logic        err;
        int          errs_at;
        seed      = 32'hc87d;
        rst       = 1'b1;
        paddr     = '0;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        pwdata    = '0;
        pstrb     = '0;
        pause_req = 1'b1; // Block comes out of reset paused
        checks    = 0;
        errors    = 0;
        build_table();
        table_ready = 1'b1;
        repeat (4) @(posedge seq);
        @(negedge seq);
        rst = 1'b0;

        errs_at = errors;
        check("pause_ack", pause_ack, 1'b1);
        pause_req = 1'b0;
        wait_ack(1'b0, 2);
        run_table(1);
        report_test(1, "reset state and pause release", errs_at);

        errs_at = errors;
        run_table(2);
        report_test(2, "strobed register access", errs_at);
        errs_at = errors;
        run_table(3);
        report_test(3, "auto-reload event and irq", errs_at);
        errs_at = errors;
        run_table(4);
        report_test(4, "event clear and irq enable", errs_at);

        errs_at = errors;
        run_table(5);
        apb_read(timer_pkg::REG_VALUE, v_before, err);
        pause_req = 1'b1;
        wait_ack(1'b1, 4);
        check("irq", irq, 1'b0);
        apb_read(timer_pkg::REG_CONTROL, rdata, err);
        check("pslverr paused", err, 1'b1);
        check("prdata paused", rdata, 32'd0);
        pause_req = 1'b0;
        wait_ack(1'b0, 4);
        apb_read(timer_pkg::REG_VALUE, v_after, err);
        // At most one divided tick lands outside the frozen window
        check("value across pause", (v_after == v_before) ||
              (v_after == ((v_before == RELOAD) ? 32'd0 : v_before + 1)), 1);
        report_test(5, "pause handshake", errs_at);

        errs_at = errors;
        run_table(6);
        report_test(6, "disable and value write", errs_at);

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end
        else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // Limit from table length and its longest wait
    initial begin
        int max_wait;
        int limit;
        wait (table_ready);
        max_wait = 0;
        foreach (steps[i]) begin
            if (steps[i].wait_cyc > max_wait) max_wait = steps[i].wait_cyc;
        end
        limit = steps.size() * (max_wait + 2 * PREADY_LIMIT) + 200;
        #(limit * 4);
        $display("Run timed out after %0d cycles", limit);
        $display("TEST FAILED");
        $finish;
    end

endmodule

// File: sources.f
+incdir+hw
hw/timer_pkg.sv
hw/timer_pause_ctrl.sv
hw/timer_counter.sv
hw/timer_apb_regs.sv
hw/apb_timer.sv
testbench/tb_apb_timer.sv

// File: Makefile
TOOL     := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := tb_apb_timer
FILELIST := sources.f
OBJ_DIR  := obj_dir
LOG      := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with $(TOOL), run $(TOP), scan $(LOG) for the fail message"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then \
		echo "Simulation reported a failure"; \
		exit 1; \
	fi
	@grep -q "TEST PASSED" $(LOG) || (echo "Simulation ended without a result"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
